/* mmr_pkg.sv */
`default_nettype none

package mmr_pkg;

    localparam int MMR_ADDR_W = 12;
    localparam int MMR_DATA_W = 32;
    localparam int MMR_STRB_W = MMR_DATA_W / 8;

    typedef logic [MMR_ADDR_W-1:0] mmr_addr_t;
    typedef logic [MMR_DATA_W-1:0] mmr_data_t;
    typedef logic [MMR_STRB_W-1:0] mmr_strb_t;
    typedef logic [1:0]            axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_DECERR = 2'b11;

    // Address map with power-of-two aligned windows
    localparam mmr_addr_t SCRATCH_BASE = 12'h000;
    localparam mmr_addr_t SCRATCH_SIZE = 12'h100;
    localparam mmr_addr_t SCRATCH_MASK = ~(SCRATCH_SIZE - 12'd1);
    localparam mmr_addr_t SPI_BASE     = 12'h100;
    localparam mmr_addr_t SPI_SIZE     = 12'h010;
    localparam mmr_addr_t SPI_MASK     = ~(SPI_SIZE - 12'd1);

    localparam int SCRATCH_WORDS = 64;
    localparam int SCRATCH_IDX_W = $clog2(SCRATCH_WORDS);
    typedef logic [SCRATCH_IDX_W-1:0] scratch_idx_t;

    // SPI register word index from address bits 3:2
    typedef logic [1:0] spi_reg_t;
    localparam spi_reg_t SPI_REG_CTRL   = 2'd0;
    localparam spi_reg_t SPI_REG_TXDATA = 2'd1;
    localparam spi_reg_t SPI_REG_RXDATA = 2'd2;
    localparam spi_reg_t SPI_REG_STATUS = 2'd3;

    localparam int SPI_BYTE_W  = 8;
    localparam int SPI_BIT_W   = $clog2(SPI_BYTE_W);
    localparam int SPI_CLK_DIV = 4;          // aclk cycles per SCK half period
    localparam int SPI_DIV_W   = $clog2(SPI_CLK_DIV);
    typedef logic [SPI_BYTE_W-1:0] spi_byte_t;
    typedef logic [SPI_BIT_W-1:0]  spi_bit_t;
    typedef logic [SPI_DIV_W-1:0]  spi_div_t;
    localparam spi_bit_t SPI_BIT_LAST = spi_bit_t'(SPI_BYTE_W - 1);
    localparam spi_div_t SPI_DIV_LAST = spi_div_t'(SPI_CLK_DIV - 1);

    typedef struct packed {
        mmr_addr_t awaddr;
        logic      awvalid;
        mmr_data_t wdata;
        mmr_strb_t wstrb;
        logic      wvalid;
        logic      bready;
        mmr_addr_t araddr;
        logic      arvalid;
        logic      rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        axil_resp_t bresp;
        logic       arready;
        logic       rvalid;
        mmr_data_t  rdata;
        axil_resp_t rresp;
    } axil_rsp_t;

    typedef enum logic [1:0] {ARB_IDLE, ARB_WRITE, ARB_READ} arb_state_t;

    typedef enum logic [1:0] {SPI_IDLE, SPI_LOW, SPI_HIGH, SPI_DONE} spi_state_t;

endpackage

`default_nettype wire

/* axil_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axil_arbiter
    import mmr_pkg::*;
(
    input  wire logic      aclk,
    input  wire logic      rst,
    input  wire axil_req_t host_req,
    output axil_rsp_t      host_rsp,
    input  wire axil_req_t cpu_req,
    output axil_rsp_t      cpu_rsp,
    output axil_req_t      bus_req,
    input  wire axil_rsp_t bus_rsp
);

    arb_state_t state;
    logic       last;       // Last and current grant with 1 for cpu
    logic       host_wr;
    logic       host_rd;
    logic       cpu_wr;
    logic       cpu_rd;
    logic       host_any;
    logic       cpu_any;
    logic       pick;
    logic       pick_wr;
    axil_req_t  gnt_req;

    assign host_wr  = host_req.awvalid && host_req.wvalid;
    assign host_rd  = host_req.arvalid;
    assign cpu_wr   = cpu_req.awvalid && cpu_req.wvalid;
    assign cpu_rd   = cpu_req.arvalid;
    assign host_any = host_wr || host_rd;
    assign cpu_any  = cpu_wr || cpu_rd;

    // Round robin on contention
    assign pick    = (host_any && cpu_any) ? ~last : cpu_any;
    assign pick_wr = pick ? cpu_wr : host_wr;   // write before read

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= ARB_IDLE;
            last  <= 1'b1;      // host wins the first contention
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (host_any || cpu_any) begin
                        state <= pick_wr ? ARB_WRITE : ARB_READ;
                        last  <= pick;
                    end
                end
                ARB_WRITE: begin
                    if (bus_rsp.bvalid && bus_req.bready) state <= ARB_IDLE;
                end
                ARB_READ: begin
                    if (bus_rsp.rvalid && bus_req.rready) state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_comb begin
        gnt_req = last ? cpu_req : host_req;

        // Only the channels of the granted direction go through
        bus_req         = gnt_req;
        bus_req.awvalid = gnt_req.awvalid && (state == ARB_WRITE);
        bus_req.wvalid  = gnt_req.wvalid && (state == ARB_WRITE);
        bus_req.bready  = gnt_req.bready && (state == ARB_WRITE);
        bus_req.arvalid = gnt_req.arvalid && (state == ARB_READ);
        bus_req.rready  = gnt_req.rready && (state == ARB_READ);

        host_rsp = '0;
        cpu_rsp  = '0;
        if (state != ARB_IDLE) begin
            if (last) cpu_rsp = bus_rsp;
            else host_rsp = bus_rsp;
        end
    end

endmodule

`default_nettype wire

/* mmr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mmr_decoder
    import mmr_pkg::*;
(
    input  wire logic      aclk,
    input  wire logic      rst,
    input  wire axil_req_t bus_req,
    output axil_rsp_t      bus_rsp,
    output axil_req_t      mem_req,
    input  wire axil_rsp_t mem_rsp,
    output axil_req_t      spi_req,
    input  wire axil_rsp_t spi_rsp
);

    typedef enum logic [1:0] {TGT_MEM, TGT_SPI, TGT_ERR} tgt_t;

    tgt_t      dec_tgt;
    tgt_t      tgt_q;
    tgt_t      cur_tgt;
    logic      busy;
    logic      wr_req;
    logic      wr_acc;
    logic      rd_acc;
    logic      err_bvalid;
    logic      err_rvalid;
    mmr_addr_t dec_addr;
    axil_rsp_t err_rsp;

    function automatic axil_req_t gate_req(axil_req_t r, logic en);
        axil_req_t g;
        g         = r;
        g.awvalid = r.awvalid && en;
        g.wvalid  = r.wvalid && en;
        g.bready  = r.bready && en;
        g.arvalid = r.arvalid && en;
        g.rready  = r.rready && en;
        return g;
    endfunction

    assign wr_req   = bus_req.awvalid && bus_req.wvalid;
    assign dec_addr = wr_req ? bus_req.awaddr : bus_req.araddr;

    always_comb begin
        if ((dec_addr & SCRATCH_MASK) == SCRATCH_BASE) dec_tgt = TGT_MEM;
        else if ((dec_addr & SPI_MASK) == SPI_BASE) dec_tgt = TGT_SPI;
        else dec_tgt = TGT_ERR;
    end

    assign cur_tgt = busy ? tgt_q : dec_tgt;   // address is gone after acceptance

    assign wr_acc = wr_req && bus_rsp.awready && bus_rsp.wready;
    assign rd_acc = bus_req.arvalid && bus_rsp.arready;

    always_ff @(posedge aclk) begin
        if (rst) begin
            busy       <= 1'b0;
            tgt_q      <= TGT_ERR;
            err_bvalid <= 1'b0;
            err_rvalid <= 1'b0;
        end else if (!busy) begin
            if (wr_acc || rd_acc) begin
                busy       <= 1'b1;
                tgt_q      <= dec_tgt;
                err_bvalid <= wr_acc && (dec_tgt == TGT_ERR);
                err_rvalid <= rd_acc && (dec_tgt == TGT_ERR);
            end
        end else if ((bus_rsp.bvalid && bus_req.bready) ||
                     (bus_rsp.rvalid && bus_req.rready)) begin
            busy       <= 1'b0;
            err_bvalid <= 1'b0;
            err_rvalid <= 1'b0;
        end
    end

    // Responder for unmapped addresses
    always_comb begin
        err_rsp         = '0;
        err_rsp.awready = !busy && wr_req;
        err_rsp.wready  = !busy && wr_req;
        err_rsp.bvalid  = err_bvalid;
        err_rsp.bresp   = RESP_DECERR;
        err_rsp.arready = !busy && !wr_req && bus_req.arvalid;
        err_rsp.rvalid  = err_rvalid;
        err_rsp.rresp   = RESP_DECERR;
    end

    assign mem_req = gate_req(bus_req, cur_tgt == TGT_MEM);
    assign spi_req = gate_req(bus_req, cur_tgt == TGT_SPI);

    always_comb begin
        case (cur_tgt)
            TGT_MEM: bus_rsp = mem_rsp;
            TGT_SPI: bus_rsp = spi_rsp;
            default: bus_rsp = err_rsp;
        endcase
    end

endmodule

`default_nettype wire

/* scratch_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module scratch_mem
    import mmr_pkg::*;
(
    input  wire logic      aclk,
    input  wire logic      rst,
    input  wire axil_req_t req,
    output axil_rsp_t      rsp
);

    mmr_data_t    mem [SCRATCH_WORDS];
    mmr_data_t    rdata_q;
    logic         bvalid_q;
    logic         rvalid_q;
    logic         wr_go;
    logic         rd_go;
    scratch_idx_t wr_idx;
    scratch_idx_t rd_idx;

    assign wr_go  = !bvalid_q && !rvalid_q && req.awvalid && req.wvalid;
    assign rd_go  = !bvalid_q && !rvalid_q && req.arvalid && !wr_go;
    assign wr_idx = req.awaddr[SCRATCH_IDX_W+1:2];   // word index
    assign rd_idx = req.araddr[SCRATCH_IDX_W+1:2];

    always_ff @(posedge aclk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_go) bvalid_q <= 1'b1;
            else if (bvalid_q && req.bready) bvalid_q <= 1'b0;

            if (rd_go) rvalid_q <= 1'b1;
            else if (rvalid_q && req.rready) rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        for (int b = 0; b < MMR_STRB_W; b++) begin
            if (wr_go && req.wstrb[b]) mem[wr_idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
        if (rd_go) rdata_q <= mem[rd_idx];
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = wr_go;
        rsp.wready  = wr_go;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = RESP_OKAY;
        rsp.arready = rd_go;
        rsp.rvalid  = rvalid_q;
        rsp.rdata   = rdata_q;
        rsp.rresp   = RESP_OKAY;
    end

endmodule

`default_nettype wire

/* qspi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module qspi_master
    import mmr_pkg::*;
(
    input  wire logic      aclk,
    input  wire logic      rst,
    input  wire axil_req_t req,
    output axil_rsp_t      rsp,
    output logic           sck,
    output logic           csn,
    output logic           mosi,
    input  wire logic      miso
);

    spi_state_t state;
    spi_div_t   div_cnt;
    spi_bit_t   bit_cnt;
    spi_byte_t  tx_shift;
    spi_byte_t  rx_shift;
    spi_byte_t  rx_data;
    spi_reg_t   w_reg;
    spi_reg_t   r_reg;
    mmr_data_t  rdata_q;
    logic       ctrl_cs;
    logic       bvalid_q;
    logic       rvalid_q;
    logic       wr_go;
    logic       rd_go;
    logic       tx_start;
    logic       div_done;
    logic       spi_busy;

    assign wr_go    = !bvalid_q && !rvalid_q && req.awvalid && req.wvalid;
    assign rd_go    = !bvalid_q && !rvalid_q && req.arvalid && !wr_go;
    assign w_reg    = req.awaddr[3:2];
    assign r_reg    = req.araddr[3:2];
    assign spi_busy = (state != SPI_IDLE);
    assign div_done = (div_cnt == SPI_DIV_LAST);
    // Writes while busy are acknowledged and dropped
    assign tx_start = wr_go && (w_reg == SPI_REG_TXDATA) && req.wstrb[0] && !spi_busy;

    always_ff @(posedge aclk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            ctrl_cs  <= 1'b0;
        end else begin
            if (wr_go) bvalid_q <= 1'b1;
            else if (bvalid_q && req.bready) bvalid_q <= 1'b0;

            if (rd_go) rvalid_q <= 1'b1;
            else if (rvalid_q && req.rready) rvalid_q <= 1'b0;

            if (wr_go && (w_reg == SPI_REG_CTRL) && req.wstrb[0]) ctrl_cs <= req.wdata[0];
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_go) begin
            case (r_reg)
                SPI_REG_CTRL:   rdata_q <= {{(MMR_DATA_W-1){1'b0}}, ctrl_cs};
                SPI_REG_RXDATA: rdata_q <= {{(MMR_DATA_W-SPI_BYTE_W){1'b0}}, rx_data};
                SPI_REG_STATUS: rdata_q <= {{(MMR_DATA_W-1){1'b0}}, spi_busy};
                default:        rdata_q <= '0;    // TXDATA is write only
            endcase
        end
    end

    // Mode 0 shift engine
    always_ff @(posedge aclk) begin
        if (rst) begin
            state    <= SPI_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            tx_shift <= '0;
            rx_data  <= '0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (tx_start) begin
                        tx_shift <= req.wdata[SPI_BYTE_W-1:0];
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        state    <= SPI_LOW;
                    end
                end
                SPI_LOW: begin
                    div_cnt <= div_done ? '0 : div_cnt + 1'b1;
                    if (div_done) state <= SPI_HIGH;
                end
                SPI_HIGH: begin
                    div_cnt <= div_done ? '0 : div_cnt + 1'b1;
                    if (div_done) begin
                        tx_shift <= {tx_shift[SPI_BYTE_W-2:0], 1'b0};  // next bit on falling edge
                        if (bit_cnt == SPI_BIT_LAST) begin
                            state <= SPI_DONE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= SPI_LOW;
                        end
                    end
                end
                SPI_DONE: begin
                    rx_data <= rx_shift;
                    state   <= SPI_IDLE;
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // Sample on the rising SCK edge
    always_ff @(posedge aclk) begin
        if ((state == SPI_LOW) && div_done) rx_shift <= {rx_shift[SPI_BYTE_W-2:0], miso};
    end

    assign sck  = (state == SPI_HIGH);
    assign csn  = ~ctrl_cs;
    assign mosi = tx_shift[SPI_BYTE_W-1];   // MSB first and zero once shifted out

    always_comb begin
        rsp         = '0;
        rsp.awready = wr_go;
        rsp.wready  = wr_go;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = RESP_OKAY;
        rsp.arready = rd_go;
        rsp.rvalid  = rvalid_q;
        rsp.rdata   = rdata_q;
        rsp.rresp   = RESP_OKAY;
    end

endmodule

`default_nettype wire

/* mmr_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mmr_top
    import mmr_pkg::*;
(
    input  wire logic      aclk,
    input  wire logic      rst,
    input  wire axil_req_t host_req,   // BAR window side
    output axil_rsp_t      host_rsp,
    input  wire axil_req_t cpu_req,    // PS general-purpose master
    output axil_rsp_t      cpu_rsp,
    output logic           sck,
    output logic           csn,
    output logic           mosi,
    input  wire logic      miso
);

    axil_req_t bus_req;
    axil_rsp_t bus_rsp;
    axil_req_t mem_req;
    axil_rsp_t mem_rsp;
    axil_req_t spi_req;
    axil_rsp_t spi_rsp;

    axil_arbiter arbiter_i (
        .aclk     (aclk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp)
    );

    mmr_decoder decoder_i (
        .aclk    (aclk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .spi_req (spi_req),
        .spi_rsp (spi_rsp)
    );

    scratch_mem mem_i (
        .aclk (aclk),
        .rst  (rst),
        .req  (mem_req),
        .rsp  (mem_rsp)
    );

    qspi_master qspi_i (
        .aclk (aclk),
        .rst  (rst),
        .req  (spi_req),
        .rsp  (spi_rsp),
        .sck  (sck),
        .csn  (csn),
        .mosi (mosi),
        .miso (miso)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;     // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* mmr_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mmr_tb
    import mmr_pkg::*;
();

    localparam logic HOST = 1'b0;
    localparam logic CPU  = 1'b1;
    localparam logic WR   = 1'b1;
    localparam logic RD   = 1'b0;
    localparam int WAIT_LIMIT = 200;
    localparam int W_ACC  = 0;
    localparam int B_VLD  = 1;
    localparam int AR_ACC = 2;
    localparam int R_VLD  = 3;

    typedef struct packed {
        logic       m;
        logic       wr;
        mmr_addr_t  addr;
        mmr_data_t  data;
        mmr_strb_t  strb;
        mmr_data_t  exp_data;
        axil_resp_t exp_resp;
    } row_t;

    logic       aclk;
    logic       rst;
    axil_req_t  host_req;
    axil_rsp_t  host_rsp;
    axil_req_t  cpu_req;
    axil_rsp_t  cpu_rsp;
    logic       sck;
    logic       csn;
    logic       mosi;
    logic       miso;
    row_t       rows [$];
    mmr_data_t  model [SCRATCH_WORDS];
    time        done_t [2];
    integer     seed;
    int         sck_rises = 0;

    assign miso = mosi;     // Loopback

    always @(posedge sck) sck_rises++;

    tb_clk_gen clk_gen_i (.clk(aclk), .rst(rst));

    mmr_top UUT (
        .aclk     (aclk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .sck      (sck),
        .csn      (csn),
        .mosi     (mosi),
        .miso     (miso)
    );

    task automatic expect_eq(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    task automatic handshake_timeout(input string what);
        $display("Timeout after %0d cycles waiting for %s at %0t ns", WAIT_LIMIT, what, $time);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    function automatic axil_rsp_t rsp_of(input logic m);
        return m ? cpu_rsp : host_rsp;
    endfunction

    function automatic logic rsp_flag(input logic m, input int sel);
        axil_rsp_t s;
        s = rsp_of(m);
        case (sel)
            W_ACC:   return s.awready && s.wready;
            B_VLD:   return s.bvalid;
            AR_ACC:  return s.arready;
            default: return s.rvalid;
        endcase
    endfunction

    task automatic drive_req(input logic m, input axil_req_t r);
        if (m) cpu_req = r;
        else host_req = r;
    endtask

    // Returns on the falling edge where the flag is seen
    task automatic wait_handshake(input logic m, input int sel, input string what);
        int n;
        n = 0;
        @(negedge aclk);
        while (!rsp_flag(m, sel)) begin
            n++;
            if (n >= WAIT_LIMIT) handshake_timeout(what);
            @(negedge aclk);
        end
    endtask

    task automatic write_txn(input logic m, input mmr_addr_t addr, input mmr_data_t data,
                             input mmr_strb_t strb, output axil_resp_t resp);
        axil_req_t r;
        axil_rsp_t s;
        r         = '0;
        r.awaddr  = addr;
        r.awvalid = 1'b1;
        r.wdata   = data;
        r.wstrb   = strb;
        r.wvalid  = 1'b1;
        r.bready  = 1'b1;
        drive_req(m, r);
        wait_handshake(m, W_ACC, "awready and wready");
        @(posedge aclk);
        #1;
        r.awvalid = 1'b0;
        r.wvalid  = 1'b0;
        drive_req(m, r);
        wait_handshake(m, B_VLD, "bvalid");
        s    = rsp_of(m);
        resp = s.bresp;
        @(posedge aclk);
        done_t[m] = $time;
        #1;
        r.bready = 1'b0;
        drive_req(m, r);
    endtask

    // Stall holds rready low for that many cycles once rvalid is up
    task automatic read_txn(input logic m, input mmr_addr_t addr, input int stall,
                            output mmr_data_t data, output axil_resp_t resp);
        axil_req_t r;
        axil_rsp_t s;
        mmr_data_t held;
        r         = '0;
        r.araddr  = addr;
        r.arvalid = 1'b1;
        r.rready  = (stall == 0);
        drive_req(m, r);
        wait_handshake(m, AR_ACC, "arready");
        @(posedge aclk);
        #1;
        r.arvalid = 1'b0;
        drive_req(m, r);
        wait_handshake(m, R_VLD, "rvalid");
        if (stall > 0) begin
            s    = rsp_of(m);
            held = s.rdata;
            repeat (stall) begin
                @(negedge aclk);
                s = rsp_of(m);
                expect_eq("rvalid during stall", s.rvalid, 1'b1);
                expect_eq("rdata during stall", s.rdata, held);
            end
            @(posedge aclk);
            #1;
            r.rready = 1'b1;
            drive_req(m, r);
            @(negedge aclk);
        end
        s    = rsp_of(m);
        data = s.rdata;
        resp = s.rresp;
        @(posedge aclk);
        done_t[m] = $time;
        #1;
        r.rready = 1'b0;
        drive_req(m, r);
    endtask

    task automatic model_write(input mmr_addr_t addr, input mmr_data_t data,
                               input mmr_strb_t strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) model[addr[7:2]][8*b +: 8] = data[8*b +: 8];
        end
    endtask

    task automatic add_row(input logic m, input logic wr, input mmr_addr_t addr,
                           input mmr_data_t data, input mmr_strb_t strb,
                           input mmr_data_t exp_data, input axil_resp_t exp_resp);
        rows.push_back('{m, wr, addr, data, strb, exp_data, exp_resp});
    endtask

    initial begin
        mmr_data_t  rd0;
        mmr_data_t  rd1;
        axil_resp_t resp0;
        axil_resp_t resp1;
        mmr_data_t  d0;
        mmr_data_t  d1;
        logic [7:0] tx_byte;
        int         n;
        int         sck_base;

        seed     = 32'hec65;
        host_req = '0;
        cpu_req  = '0;

        //      master wr  addr     data          strb  exp data      exp resp
        add_row(HOST, WR, 12'h000, 32'h1122_3344, 4'hF, 32'h0,        RESP_OKAY);
        add_row(HOST, WR, 12'h004, 32'hA5A5_0F0F, 4'hF, 32'h0,        RESP_OKAY);
        add_row(CPU,  RD, 12'h000, 32'h0,         4'h0, 32'h1122_3344, RESP_OKAY);
        add_row(CPU,  WR, 12'h0FC, 32'hDEAD_BEEF, 4'hF, 32'h0,        RESP_OKAY);
        add_row(HOST, RD, 12'h0FC, 32'h0,         4'h0, 32'hDEAD_BEEF, RESP_OKAY);
        add_row(HOST, WR, 12'h000, 32'hAABB_CCDD, 4'h5, 32'h0,        RESP_OKAY);
        add_row(CPU,  RD, 12'h000, 32'h0,         4'h0, 32'h11BB_33DD, RESP_OKAY);
        add_row(HOST, WR, 12'h200, 32'h1234_5678, 4'hF, 32'h0,        RESP_DECERR);
        add_row(CPU,  RD, 12'h200, 32'h0,         4'h0, 32'h0,        RESP_DECERR);
        add_row(CPU,  RD, 12'h004, 32'h0,         4'h0, 32'hA5A5_0F0F, RESP_OKAY);

        n = 0;
        @(negedge aclk);
        while (rst) begin
            n++;
            if (n >= WAIT_LIMIT) handshake_timeout("reset release");
            @(negedge aclk);
        end
        expect_eq("host ready and valid after reset",
                  {host_rsp.awready, host_rsp.wready, host_rsp.bvalid,
                   host_rsp.arready, host_rsp.rvalid}, 32'h0);
        expect_eq("cpu ready and valid after reset",
                  {cpu_rsp.awready, cpu_rsp.wready, cpu_rsp.bvalid,
                   cpu_rsp.arready, cpu_rsp.rvalid}, 32'h0);
        expect_eq("sck after reset", sck, 1'b0);
        expect_eq("csn after reset", csn, 1'b1);
        expect_eq("mosi after reset", mosi, 1'b0);
        @(posedge aclk);
        #1;

        foreach (rows[i]) begin
            if (rows[i].wr) begin
                write_txn(rows[i].m, rows[i].addr, rows[i].data, rows[i].strb, resp0);
                expect_eq($sformatf("row %0d bresp", i), resp0, rows[i].exp_resp);
                if (rows[i].addr < SCRATCH_SIZE) model_write(rows[i].addr, rows[i].data,
                                                             rows[i].strb);
            end else begin
                read_txn(rows[i].m, rows[i].addr, 0, rd0, resp0);
                expect_eq($sformatf("row %0d rresp", i), resp0, rows[i].exp_resp);
                expect_eq($sformatf("row %0d rdata", i), rd0, rows[i].exp_data);
                if (rows[i].addr < SCRATCH_SIZE)
                    expect_eq($sformatf("row %0d rdata vs model", i), rd0,
                              model[rows[i].addr[7:2]]);
            end
        end

        // Both masters write in the same cycle
        d0 = $random(seed);
        d1 = $random(seed);
        fork
            write_txn(HOST, 12'h040, d0, 4'hF, resp0);
            write_txn(CPU, 12'h080, d1, 4'hF, resp1);
        join
        expect_eq("host bresp in contention", resp0, RESP_OKAY);
        expect_eq("cpu bresp in contention", resp1, RESP_OKAY);
        model_write(12'h040, d0, 4'hF);
        model_write(12'h080, d1, 4'hF);
        read_txn(CPU, 12'h040, 0, rd0, resp0);
        expect_eq("cpu reads host word", rd0, model[6'h10]);
        read_txn(HOST, 12'h080, 0, rd1, resp1);
        expect_eq("host reads cpu word", rd1, model[6'h20]);

        // SPI loopback
        write_txn(HOST, SPI_BASE, 32'h1, 4'hF, resp0);
        expect_eq("CTRL bresp", resp0, RESP_OKAY);
        @(negedge aclk);
        expect_eq("csn with CTRL set", csn, 1'b0);
        @(posedge aclk);
        #1;
        tx_byte  = $random(seed);
        sck_base = sck_rises;
        write_txn(CPU, SPI_BASE + 12'h4, {24'h0, tx_byte}, 4'hF, resp0);
        expect_eq("TXDATA bresp", resp0, RESP_OKAY);
        read_txn(HOST, SPI_BASE + 12'hC, 0, rd0, resp0);
        expect_eq("STATUS busy after TXDATA", rd0, 32'h1);
        write_txn(HOST, SPI_BASE + 12'h4, {24'h0, ~tx_byte}, 4'hF, resp0);
        expect_eq("TXDATA bresp while busy", resp0, RESP_OKAY);
        n = 0;
        do begin
            read_txn(CPU, SPI_BASE + 12'hC, 0, rd0, resp0);
            n++;
            if (n >= WAIT_LIMIT) handshake_timeout("SPI busy to clear");
        end while (rd0[0]);
        expect_eq("SCK rising edges in one transfer", sck_rises - sck_base, 32'd8);
        read_txn(HOST, SPI_BASE + 12'h8, 0, rd0, resp0);
        expect_eq("RXDATA rresp", resp0, RESP_OKAY);
        expect_eq("RXDATA loopback", rd0, {24'h0, tx_byte});
        write_txn(CPU, SPI_BASE, 32'h0, 4'hF, resp0);
        @(negedge aclk);
        expect_eq("csn with CTRL clear", csn, 1'b1);
        @(posedge aclk);
        #1;

        // Host stalls its read response while the cpu waits behind it
        fork
            read_txn(HOST, 12'h040, 10, rd0, resp0);
            begin
                @(posedge aclk);
                #1;
                read_txn(CPU, 12'h080, 0, rd1, resp1);
            end
        join
        expect_eq("stalled host rdata", rd0, model[6'h10]);
        expect_eq("stalled host rresp", resp0, RESP_OKAY);
        expect_eq("cpu rdata after stall", rd1, model[6'h20]);
        expect_eq("cpu rresp after stall", resp1, RESP_OKAY);
        expect_eq("cpu done after host", done_t[CPU] > done_t[HOST], 1'b1);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
mmr_pkg.sv
axil_arbiter.sv
mmr_decoder.sv
scratch_mem.sv
qspi_master.sv
mmr_top.sv
tb_clk_gen.sv
mmr_tb.sv

/* Bender.yml */
package:
  name: mmr_island

sources:
  - files:
      - mmr_pkg.sv
      - axil_arbiter.sv
      - mmr_decoder.sv
      - scratch_mem.sv
      - qspi_master.sv
      - mmr_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - mmr_tb.sv
